// ==== source/mcu_pkg.sv ====
`default_nettype none

package mcu_pkg;

  // Global controller states, broadcast to every sequencer
  typedef enum logic [2:0] {
    GLO_IDLE,
    GLO_STR,
    GLO_RUN,
    GLO_END,
    GLO_ERR
  } mcu_glo_state_e;

  // Per-buffer sequencer states
  typedef enum logic [1:0] {
    LOC_STR,
    LOC_OPE,
    LOC_END,
    LOC_ERR
  } mcu_loc_state_e;

  // Element-wise combine operations
  typedef enum logic [1:0] {
    OP_ADD,
    OP_SUB,
    OP_MUL,
    OP_MAX
  } mcu_op_e;

  localparam int DATA_WIDTH_DEF = 16;
  localparam int ADDR_WIDTH_DEF = 10;
  localparam int ITER_WIDTH_DEF = 16;

endpackage

`default_nettype wire

// ==== source/mcu_stream_if.sv ====
`default_nettype none

interface mcu_stream_if #(
  parameter int DATA_WIDTH = mcu_pkg::DATA_WIDTH_DEF
);

  logic [DATA_WIDTH-1:0] data;
  logic                  valid;
  logic                  ready;
  logic                  last;

  // Producer side
  modport src (output data, output valid, output last, input ready);

  // Consumer side
  modport snk (input data, input valid, input last, output ready);

endinterface

`default_nettype wire

// ==== source/mcu_global_fsm.sv ====
`default_nettype none

module mcu_global_fsm (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    start,
  input  logic                    tlast_a,
  input  logic                    tlast_b,
  input  logic                    err_a,
  input  logic                    err_b,
  input  logic                    mismatch,
  output mcu_pkg::mcu_glo_state_e glo_state,
  output logic                    busy,
  output logic                    done,
  output logic                    error
);

  import mcu_pkg::*;

  mcu_glo_state_e state_next;
  logic           fin_a;
  logic           fin_b;
  logic           all_fin;
  logic           any_err;

  // Sequencers may finish on different cycles
  assign all_fin = (fin_a || tlast_a) && (fin_b || tlast_b);
  assign any_err = err_a || err_b || mismatch;

  always_comb begin
    state_next = glo_state;
    case (glo_state)
      GLO_IDLE: begin
        if (start) begin
          state_next = GLO_STR;
        end
      end
      GLO_STR: begin
        state_next = GLO_RUN;
      end
      GLO_RUN: begin
        // Errors win over completion
        if (any_err) begin
          state_next = GLO_ERR;
        end else if (all_fin) begin
          state_next = GLO_END;
        end
      end
      GLO_END: begin
        state_next = GLO_IDLE;
      end
      GLO_ERR: begin
        state_next = GLO_IDLE;
      end
      default: begin
        state_next = GLO_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      glo_state <= GLO_IDLE;
      fin_a     <= 1'b0;
      fin_b     <= 1'b0;
    end else begin
      glo_state <= state_next;
      // Completion flags only collect while running
      fin_a     <= (glo_state == GLO_RUN) && (fin_a || tlast_a);
      fin_b     <= (glo_state == GLO_RUN) && (fin_b || tlast_b);
    end
  end

  assign busy  = (glo_state != GLO_IDLE);
  assign done  = (glo_state == GLO_END);
  assign error = (glo_state == GLO_ERR);

endmodule

`default_nettype wire

// ==== source/mcu_bram_reader.sv ====
`default_nettype none

module mcu_bram_reader #(
  parameter int DATA_WIDTH     = mcu_pkg::DATA_WIDTH_DEF,
  parameter int ADDR_WIDTH     = mcu_pkg::ADDR_WIDTH_DEF,
  parameter int ITER_WIDTH     = mcu_pkg::ITER_WIDTH_DEF,
  parameter int BRAM_VALID_SIG = 1
) (
  input  logic                    clk,
  input  logic                    rst,
  input  mcu_pkg::mcu_glo_state_e glo_state,
  input  logic [ADDR_WIDTH:0]     addr_max,
  input  logic [ITER_WIDTH-1:0]   inter_max,
  input  logic [ITER_WIDTH-1:0]   intra_max,
  output logic                    bram_en,
  output logic [ADDR_WIDTH-1:0]   bram_addr,
  input  logic [DATA_WIDTH-1:0]   bram_rddata,
  input  logic                    bram_rdack,
  mcu_stream_if.src               out,
  output logic                    tlast_transmitted,
  output logic                    error
);

  import mcu_pkg::*;

  mcu_loc_state_e        loc_state;
  mcu_loc_state_e        loc_next;
  logic [ADDR_WIDTH-1:0] addr;
  logic [ITER_WIDTH-1:0] inter_cnt;
  logic [ITER_WIDTH-1:0] intra_cnt;
  logic [ADDR_WIDTH:0]   addr_top;
  logic [ITER_WIDTH-1:0] inter_top;
  logic [ITER_WIDTH-1:0] intra_top;
  logic                  addr_wrap;
  logic                  final_read;
  logic                  flush;
  logic                  en_q;
  logic                  last_q;
  logic                  rd_valid;
  logic [1:0]            count;
  logic [2:0]            fill;
  logic                  beat;
  logic                  final_rep;
  logic                  pop;
  logic [DATA_WIDTH-1:0] d0;
  logic [DATA_WIDTH-1:0] d1;
  logic                  l0;
  logic                  l1;
  logic                  tlast_q;

  assign flush      = (glo_state == GLO_ERR);
  assign addr_top   = addr_max - 1'b1;
  assign inter_top  = inter_max - 1'b1;
  assign intra_top  = intra_max - 1'b1;
  assign addr_wrap  = ({1'b0, addr} == addr_top);
  assign final_read = addr_wrap && (inter_cnt == inter_top);

  // Read data qualifier, acknowledge or fixed one-cycle latency
  if (BRAM_VALID_SIG != 0) begin : g_ack
    assign rd_valid = bram_rdack;
  end else begin : g_lat
    assign rd_valid = en_q;
  end

  // Output side of the skid buffer
  assign final_rep  = (intra_cnt == intra_top);
  assign beat       = out.valid && out.ready;
  assign pop        = beat && final_rep;
  assign out.valid  = (count != 2'd0);
  assign out.data   = d0;
  assign out.last   = l0 && final_rep;

  // Stored words plus the read in flight, after this cycle's pop
  assign fill    = {1'b0, count} + {2'b00, en_q} - {2'b00, pop};
  assign bram_en = (loc_state == LOC_OPE) && !flush && (fill < 3'd2);
  assign bram_addr = addr;

  always_comb begin
    loc_next = loc_state;
    case (loc_state)
      LOC_STR: begin
        if (glo_state == GLO_STR) begin
          if (addr_max == '0 || inter_max == '0 || intra_max == '0) begin
            loc_next = LOC_ERR;
          end else begin
            loc_next = LOC_OPE;
          end
        end
      end
      LOC_OPE: begin
        if (flush) begin
          loc_next = LOC_STR;
        end else if (bram_en && final_read) begin
          loc_next = LOC_END;
        end
      end
      LOC_END: begin
        if (glo_state == GLO_END || flush) begin
          loc_next = LOC_STR;
        end
      end
      LOC_ERR: begin
        if (flush) begin
          loc_next = LOC_STR;
        end
      end
      default: begin
        loc_next = LOC_STR;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      loc_state <= LOC_STR;
      en_q      <= 1'b0;
      last_q    <= 1'b0;
    end else begin
      loc_state <= loc_next;
      en_q      <= bram_en;
      // Tag travels with the read of the final word
      last_q    <= bram_en && final_read;
    end
  end

  // Address and inter-iteration counters
  always_ff @(posedge clk) begin
    if (rst || loc_state == LOC_STR) begin
      addr      <= '0;
      inter_cnt <= '0;
    end else if (bram_en) begin
      if (addr_wrap) begin
        addr      <= '0;
        inter_cnt <= inter_cnt + 1'b1;
      end else begin
        addr <= addr + 1'b1;
      end
    end
  end

  // Repeat count of the head word
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      intra_cnt <= '0;
    end else if (beat) begin
      intra_cnt <= final_rep ? '0 : intra_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      count <= 2'd0;
    end else begin
      case ({rd_valid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Two-entry skid storage, d0 is the head
  always_ff @(posedge clk) begin
    if (pop) begin
      d0 <= d1;
      l0 <= l1;
    end
    if (rd_valid) begin
      if (count == 2'd0 || (count == 2'd1 && pop)) begin
        d0 <= bram_rddata;
        l0 <= last_q;
      end else begin
        d1 <= bram_rddata;
        l1 <= last_q;
      end
    end
  end

  // Held until the sequencer is released back to start
  always_ff @(posedge clk) begin
    if (rst || loc_state == LOC_STR) begin
      tlast_q <= 1'b0;
    end else if (beat && out.last) begin
      tlast_q <= 1'b1;
    end
  end

  assign tlast_transmitted = tlast_q;
  assign error             = (loc_state == LOC_ERR);

endmodule

`default_nettype wire

// ==== source/mcu_stream_combine.sv ====
`default_nettype none

module mcu_stream_combine #(
  parameter int DATA_WIDTH = mcu_pkg::DATA_WIDTH_DEF
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  flush,
  input  mcu_pkg::mcu_op_e      op,
  mcu_stream_if.snk             a,
  mcu_stream_if.snk             b,
  output logic [DATA_WIDTH-1:0] res_data,
  output logic                  res_valid,
  output logic                  res_last,
  input  logic                  res_ready,
  output logic                  mismatch
);

  import mcu_pkg::*;

  logic                  take;
  logic [DATA_WIDTH-1:0] res_next;

  // Join both inputs when the output register is free or draining
  assign take    = a.valid && b.valid && (!res_valid || res_ready) && !flush;
  assign a.ready = take;
  assign b.ready = take;

  always_comb begin
    case (op)
      OP_ADD:  res_next = a.data + b.data;
      OP_SUB:  res_next = a.data - b.data;
      // Low half of the product
      OP_MUL:  res_next = a.data * b.data;
      OP_MAX:  res_next = (a.data > b.data) ? a.data : b.data;
      default: res_next = a.data;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid <= 1'b0;
      res_last  <= 1'b0;
      mismatch  <= 1'b0;
    end else if (flush) begin
      res_valid <= 1'b0;
      mismatch  <= 1'b0;
    end else begin
      if (take) begin
        res_valid <= 1'b1;
        res_last  <= a.last;
        // Streams of unequal length end on different beats
        if (a.last != b.last) begin
          mismatch <= 1'b1;
        end
      end else if (res_ready) begin
        res_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      res_data <= '0;
    end else if (take) begin
      res_data <= res_next;
    end
  end

endmodule

`default_nettype wire

// ==== source/mcu_top.sv ====
`default_nettype none

module mcu_top #(
  parameter int DATA_WIDTH     = mcu_pkg::DATA_WIDTH_DEF,
  parameter int ADDR_WIDTH     = mcu_pkg::ADDR_WIDTH_DEF,
  parameter int ITER_WIDTH     = mcu_pkg::ITER_WIDTH_DEF,
  parameter int BRAM_VALID_SIG = 1
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start,
  input  mcu_pkg::mcu_op_e      op,
  input  logic [ITER_WIDTH-1:0] inter_max,
  input  logic [ADDR_WIDTH:0]   addr_max_a,
  input  logic [ITER_WIDTH-1:0] intra_max_a,
  input  logic [ADDR_WIDTH:0]   addr_max_b,
  input  logic [ITER_WIDTH-1:0] intra_max_b,
  output logic                  busy,
  output logic                  done,
  output logic                  error,
  output logic                  bram_a_en,
  output logic [ADDR_WIDTH-1:0] bram_a_addr,
  input  logic [DATA_WIDTH-1:0] bram_a_rddata,
  input  logic                  bram_a_rdack,
  output logic                  bram_b_en,
  output logic [ADDR_WIDTH-1:0] bram_b_addr,
  input  logic [DATA_WIDTH-1:0] bram_b_rddata,
  input  logic                  bram_b_rdack,
  output logic [DATA_WIDTH-1:0] res_data,
  output logic                  res_valid,
  output logic                  res_last,
  input  logic                  res_ready
);

  import mcu_pkg::*;

  mcu_glo_state_e glo_state;
  logic           tlast_a;
  logic           tlast_b;
  logic           err_a;
  logic           err_b;
  logic           mismatch;

  mcu_stream_if #(.DATA_WIDTH(DATA_WIDTH)) str_a ();
  mcu_stream_if #(.DATA_WIDTH(DATA_WIDTH)) str_b ();

  mcu_global_fsm glo_i (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .tlast_a   (tlast_a),
    .tlast_b   (tlast_b),
    .err_a     (err_a),
    .err_b     (err_b),
    .mismatch  (mismatch),
    .glo_state (glo_state),
    .busy      (busy),
    .done      (done),
    .error     (error)
  );

  mcu_bram_reader #(
    .DATA_WIDTH     (DATA_WIDTH),
    .ADDR_WIDTH     (ADDR_WIDTH),
    .ITER_WIDTH     (ITER_WIDTH),
    .BRAM_VALID_SIG (BRAM_VALID_SIG)
  ) rd_a_i (
    .clk               (clk),
    .rst               (rst),
    .glo_state         (glo_state),
    .addr_max          (addr_max_a),
    .inter_max         (inter_max),
    .intra_max         (intra_max_a),
    .bram_en           (bram_a_en),
    .bram_addr         (bram_a_addr),
    .bram_rddata       (bram_a_rddata),
    .bram_rdack        (bram_a_rdack),
    .out               (str_a.src),
    .tlast_transmitted (tlast_a),
    .error             (err_a)
  );

  mcu_bram_reader #(
    .DATA_WIDTH     (DATA_WIDTH),
    .ADDR_WIDTH     (ADDR_WIDTH),
    .ITER_WIDTH     (ITER_WIDTH),
    .BRAM_VALID_SIG (BRAM_VALID_SIG)
  ) rd_b_i (
    .clk               (clk),
    .rst               (rst),
    .glo_state         (glo_state),
    .addr_max          (addr_max_b),
    .inter_max         (inter_max),
    .intra_max         (intra_max_b),
    .bram_en           (bram_b_en),
    .bram_addr         (bram_b_addr),
    .bram_rddata       (bram_b_rddata),
    .bram_rdack        (bram_b_rdack),
    .out               (str_b.src),
    .tlast_transmitted (tlast_b),
    .error             (err_b)
  );

  // Error output is high exactly in GLO_ERR, so it doubles as flush
  mcu_stream_combine #(
    .DATA_WIDTH (DATA_WIDTH)
  ) comb_i (
    .clk       (clk),
    .rst       (rst),
    .flush     (error),
    .op        (op),
    .a         (str_a.snk),
    .b         (str_b.snk),
    .res_data  (res_data),
    .res_valid (res_valid),
    .res_last  (res_last),
    .res_ready (res_ready),
    .mismatch  (mismatch)
  );

endmodule

`default_nettype wire

// ==== sim/mcu_tb.sv ====
`default_nettype none

module mcu_tb;

  import mcu_pkg::*;

  localparam int DATA_WIDTH  = DATA_WIDTH_DEF;
  localparam int ADDR_WIDTH  = ADDR_WIDTH_DEF;
  localparam int ITER_WIDTH  = ITER_WIDTH_DEF;
  localparam int CLK_PERIOD  = 100;
  localparam int DRIVE_DELAY = 10;
  localparam int WAIT_CYCLES = 200;

  // Legal run shape, shared by every opcode run
  localparam int RUN_INTER   = 2;
  localparam int RUN_ADDR_A  = 4;
  localparam int RUN_INTRA_A = 1;
  localparam int RUN_ADDR_B  = 2;
  localparam int RUN_INTRA_B = 2;
  localparam int RUN_BEATS   = RUN_INTER * RUN_ADDR_A * RUN_INTRA_A;

  // Five legal runs plus the four beats of the mismatch run
  localparam int TOTAL_BEATS   = 5 * RUN_BEATS + 4;
  localparam int WATCHDOG_TIME = 20 * TOTAL_BEATS * CLK_PERIOD + 2000;

  logic                  clk;
  logic                  rst;
  logic                  start;
  mcu_op_e               op;
  logic [ITER_WIDTH-1:0] inter_max;
  logic [ADDR_WIDTH:0]   addr_max_a;
  logic [ITER_WIDTH-1:0] intra_max_a;
  logic [ADDR_WIDTH:0]   addr_max_b;
  logic [ITER_WIDTH-1:0] intra_max_b;
  logic                  busy;
  logic                  done;
  logic                  error;
  logic                  bram_a_en;
  logic [ADDR_WIDTH-1:0] bram_a_addr;
  logic [DATA_WIDTH-1:0] bram_a_rddata;
  logic                  bram_a_rdack;
  logic                  bram_b_en;
  logic [ADDR_WIDTH-1:0] bram_b_addr;
  logic [DATA_WIDTH-1:0] bram_b_rddata;
  logic                  bram_b_rdack;
  logic [DATA_WIDTH-1:0] res_data;
  logic                  res_valid;
  logic                  res_last;
  logic                  res_ready;

  logic [DATA_WIDTH-1:0] mem_a [0:(1<<ADDR_WIDTH)-1];
  logic [DATA_WIDTH-1:0] mem_b [0:(1<<ADDR_WIDTH)-1];
  logic                  en_a_s;
  logic                  en_b_s;
  logic [ADDR_WIDTH-1:0] addr_a_s;
  logic [ADDR_WIDTH-1:0] addr_b_s;

  logic [DATA_WIDTH-1:0] exp_data_q [$];
  logic                  exp_last_q [$];
  logic                  check_data;
  int                    beat_count;
  int                    stray_beats;
  int                    done_count;
  int                    error_count;
  int                    fail_count;

  mcu_top #(
    .BRAM_VALID_SIG (1)
  ) dut_i (
    .clk           (clk),
    .rst           (rst),
    .start         (start),
    .op            (op),
    .inter_max     (inter_max),
    .addr_max_a    (addr_max_a),
    .intra_max_a   (intra_max_a),
    .addr_max_b    (addr_max_b),
    .intra_max_b   (intra_max_b),
    .busy          (busy),
    .done          (done),
    .error         (error),
    .bram_a_en     (bram_a_en),
    .bram_a_addr   (bram_a_addr),
    .bram_a_rddata (bram_a_rddata),
    .bram_a_rdack  (bram_a_rdack),
    .bram_b_en     (bram_b_en),
    .bram_b_addr   (bram_b_addr),
    .bram_b_rddata (bram_b_rddata),
    .bram_b_rdack  (bram_b_rdack),
    .res_data      (res_data),
    .res_valid     (res_valid),
    .res_last      (res_last),
    .res_ready     (res_ready)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic stop_run(input string line);
    fail_count++;
    $display("%s", line);
    $display("STATUS: FAIL");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic value_error(input string msg);
    stop_run($sformatf("MISMATCH at time %0t: %s", $time, msg));
  endtask

  task automatic flow_error(input string msg);
    stop_run($sformatf("ERROR at time %0t: %s", $time, msg));
  endtask

  task automatic next_cycle;
    @(posedge clk);
    #(DRIVE_DELAY);
  endtask

  // Wrapping arithmetic, unsigned maximum
  function automatic logic [DATA_WIDTH-1:0] apply_op(input mcu_op_e o,
                                                     input logic [DATA_WIDTH-1:0] x,
                                                     input logic [DATA_WIDTH-1:0] y);
    case (o)
      OP_ADD:  return x + y;
      OP_SUB:  return x - y;
      OP_MUL:  return x * y;
      default: return (x > y) ? x : y;
    endcase
  endfunction

  task automatic load_expected(input mcu_op_e o);
    logic [DATA_WIDTH-1:0] beats_a [$];
    logic [DATA_WIDTH-1:0] beats_b [$];
    int                    total;
    // Iterations outermost, then addresses, then repeats of one word
    for (int i = 0; i < RUN_INTER; i++) begin
      for (int j = 0; j < RUN_ADDR_A; j++) begin
        for (int k = 0; k < RUN_INTRA_A; k++) begin
          beats_a.push_back(mem_a[ADDR_WIDTH'(j)]);
        end
      end
      for (int j = 0; j < RUN_ADDR_B; j++) begin
        for (int k = 0; k < RUN_INTRA_B; k++) begin
          beats_b.push_back(mem_b[ADDR_WIDTH'(j)]);
        end
      end
    end
    total = beats_a.size();
    exp_data_q.delete();
    exp_last_q.delete();
    for (int k = 0; k < total; k++) begin
      exp_data_q.push_back(apply_op(o, beats_a[k], beats_b[k]));
      exp_last_q.push_back(k == total - 1);
    end
  endtask

  task automatic check_beat(input logic [DATA_WIDTH-1:0] data, input logic last);
    logic [DATA_WIDTH-1:0] exp_data;
    logic                  exp_last;
    if (exp_data_q.size() == 0) begin
      flow_error("result beat arrived with no beat expected");
    end else begin
      exp_data = exp_data_q.pop_front();
      exp_last = exp_last_q.pop_front();
      assert (data === exp_data)
        else value_error($sformatf("beat %0d data %h, expected %h", beat_count, data, exp_data));
      assert (last === exp_last)
        else value_error($sformatf("beat %0d last %b, expected %b", beat_count, last, exp_last));
      beat_count++;
    end
  endtask

  task automatic set_limits(input int inter, input int am_a, input int im_a,
                            input int am_b, input int im_b);
    inter_max   = ITER_WIDTH'(inter);
    addr_max_a  = (ADDR_WIDTH + 1)'(am_a);
    intra_max_a = ITER_WIDTH'(im_a);
    addr_max_b  = (ADDR_WIDTH + 1)'(am_b);
    intra_max_b = ITER_WIDTH'(im_b);
  endtask

  task automatic pulse_start;
    start = 1'b1;
    next_cycle();
    start = 1'b0;
  endtask

  // Done seen and the final result register drained
  task automatic await_done(input int done_before);
    int cycles;
    cycles = 0;
    while (done_count == done_before || res_valid) begin
      next_cycle();
      cycles++;
      if (cycles > WAIT_CYCLES) begin
        flow_error("legal run did not complete and drain");
      end
    end
  endtask

  task automatic await_error(input int error_before);
    int cycles;
    cycles = 0;
    while (error_count == error_before) begin
      next_cycle();
      cycles++;
      if (cycles > WAIT_CYCLES) begin
        flow_error("no error pulse for an illegal run");
      end
    end
  endtask

  task automatic run_legal(input mcu_op_e o, input logic extra_start);
    int done_before;
    int error_before;
    done_before  = done_count;
    error_before = error_count;
    load_expected(o);
    beat_count = 0;
    op = o;
    set_limits(RUN_INTER, RUN_ADDR_A, RUN_INTRA_A, RUN_ADDR_B, RUN_INTRA_B);
    pulse_start();
    if (extra_start) begin
      repeat (3) next_cycle();
      assert (busy) else flow_error("run was not busy when the second start came");
      pulse_start();
    end
    await_done(done_before);
    repeat (4) next_cycle();
    assert (done_count == done_before + 1) else flow_error("done did not pulse exactly once");
    assert (error_count == error_before) else flow_error("error pulse in a legal run");
    assert (beat_count == RUN_BEATS)
      else value_error($sformatf("%0d result beats, expected %0d", beat_count, RUN_BEATS));
  endtask

  task automatic run_failing(input int inter, input int am_a, input int im_a,
                             input int am_b, input int im_b, input logic no_beats);
    int done_before;
    int error_before;
    done_before  = done_count;
    error_before = error_count;
    check_data   = 1'b0;
    stray_beats  = 0;
    set_limits(inter, am_a, im_a, am_b, im_b);
    pulse_start();
    await_error(error_before);
    repeat (4) next_cycle();
    assert (error_count == error_before + 1) else flow_error("error did not pulse exactly once");
    assert (done_count == done_before) else flow_error("done pulsed in an illegal run");
    if (no_beats) begin
      assert (stray_beats == 0) else flow_error("result beats after a limit error");
    end
    check_data = 1'b1;
  endtask

  // Memory models, one cycle of latency with acknowledge
  always @(posedge clk) begin
    en_a_s   = bram_a_en;
    addr_a_s = bram_a_addr;
    en_b_s   = bram_b_en;
    addr_b_s = bram_b_addr;
    // Reads stay below the word count of the run
    if (en_a_s) begin
      assert ({1'b0, addr_a_s} < addr_max_a)
        else value_error($sformatf("memory A address %0d beyond the word count", addr_a_s));
    end
    if (en_b_s) begin
      assert ({1'b0, addr_b_s} < addr_max_b)
        else value_error($sformatf("memory B address %0d beyond the word count", addr_b_s));
    end
    #(DRIVE_DELAY);
    bram_a_rdack = en_a_s;
    bram_b_rdack = en_b_s;
    if (en_a_s) begin
      bram_a_rddata = mem_a[addr_a_s];
    end
    if (en_b_s) begin
      bram_b_rddata = mem_b[addr_b_s];
    end
  end

  // Random back-pressure, ready about two cycles in three
  always @(posedge clk) begin
    #(DRIVE_DELAY);
    res_ready = ($urandom % 3) != 0;
  end

  always @(posedge clk) begin
    if (!rst) begin
      if (done) begin
        done_count = done_count + 1;
      end
      if (error) begin
        error_count = error_count + 1;
      end
      if (res_valid && res_ready) begin
        if (check_data) begin
          check_beat(res_data, res_last);
        end else begin
          stray_beats = stray_beats + 1;
        end
      end
    end
  end

  // A stalled result holds until it transfers
  assert property (@(posedge clk) disable iff (rst)
    (res_valid && !res_ready && !error) |=> (res_valid && $stable(res_data) && $stable(res_last)))
    else value_error("result stream changed while stalled");

  assert property (@(posedge clk) disable iff (rst) done |=> (!done && !busy))
    else flow_error("done longer than one cycle or busy still high after it");

  assert property (@(posedge clk) disable iff (rst) error |=> !error)
    else flow_error("error pulse longer than one cycle");

  initial begin
    #(WATCHDOG_TIME);
    flow_error("watchdog timeout, the tests did not finish in time");
  end

  initial begin
    void'($urandom(68958));
    rst           = 1'b1;
    start         = 1'b0;
    op            = OP_ADD;
    set_limits(0, 0, 0, 0, 0);
    bram_a_rddata = '0;
    bram_a_rdack  = 1'b0;
    bram_b_rddata = '0;
    bram_b_rdack  = 1'b0;
    res_ready     = 1'b0;
    check_data    = 1'b1;
    beat_count    = 0;
    stray_beats   = 0;
    done_count    = 0;
    error_count   = 0;
    fail_count    = 0;
    for (int i = 0; i < (1 << ADDR_WIDTH); i++) begin
      mem_a[ADDR_WIDTH'(i)] = DATA_WIDTH'($urandom);
      mem_b[ADDR_WIDTH'(i)] = DATA_WIDTH'($urandom);
    end

    repeat (3) @(posedge clk);
    #(DRIVE_DELAY);
    rst = 1'b0;
    assert (!bram_a_en && !bram_b_en && bram_a_addr == '0 && bram_b_addr == '0
            && !res_valid && !res_last && res_data == '0 && !busy && !done && !error)
      else flow_error("outputs not idle after reset");

    run_legal(OP_ADD, 1'b0);
    run_legal(OP_SUB, 1'b0);
    run_legal(OP_MUL, 1'b0);
    // Second start lands mid-run
    run_legal(OP_MAX, 1'b1);

    // Zero limits, one per kind
    run_failing(0, 4, 1, 4, 1, 1'b1);
    run_failing(2, 4, 0, 2, 2, 1'b1);
    run_failing(2, 4, 1, 0, 2, 1'b1);
    run_legal(OP_ADD, 1'b0);

    // Totals of four and two beats
    run_failing(1, 4, 1, 2, 1, 1'b0);

    if (fail_count == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      stop_run("ERROR: checks failed during the run");
    end
  end

endmodule

`default_nettype wire

// ==== tb.f ====
source/mcu_pkg.sv
source/mcu_stream_if.sv
source/mcu_global_fsm.sv
source/mcu_bram_reader.sv
source/mcu_stream_combine.sv
source/mcu_top.sv
sim/mcu_tb.sv

// ==== Bender.yml ====
package:
  name: mcu

sources:
  - source/mcu_pkg.sv
  - source/mcu_stream_if.sv
  - source/mcu_global_fsm.sv
  - source/mcu_bram_reader.sv
  - source/mcu_stream_combine.sv
  - source/mcu_top.sv
  - target: test
    files:
      - sim/mcu_tb.sv
